/* Makefile */
TOP = cpuCoreTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* common/cpuCorePkg.sv */
package cpuCorePkg;

  import cpuIsaPkg::*;

  // One state per bus phase of an instruction
  typedef enum logic [3:0] {
    fetchReq, fetchWait, decode, operandRead,
    constWait, constLatch,
    memReq, memWait, memLatch,
    writeBack
  } seqStateE;

  typedef enum logic [1:0] {memNone, memRead, memWrite} memKindE;

  typedef enum logic [1:0] {spNone, spPlus, spMinus} spDeltaE; // Stack pointer effect

  typedef struct packed {
    opcodeE  opcode;
    logic    isLong;       // Carries a constant word
    memKindE memKind;
    logic    writesDest;   // Register write at write-back
    logic    destFromLoad; // Loaded word instead of ALU result
    spDeltaE spDelta;
    logic    haltsIp;      // Stall keeps the pointer
    logic    isJump;
  } decodedOpT;

  typedef struct packed {
    wordT addr;
    wordT wrData;
    logic readReq;
    logic writeReq;
  } busReqT;

  typedef struct packed {
    logic   en;
    regIdxT idx;
    wordT   data;
  } regWriteT;

endpackage

/* common/cpuIsaPkg.sv */
package cpuIsaPkg;

  typedef logic [31:0] wordT; // Bus and register word

  // Low six bits of each index byte select the register
  localparam int regIdxW = 6;
  typedef logic [regIdxW-1:0] regIdxT;

  localparam regIdxT stackRegIdx = 6'd0; // r0 holds the stack pointer
  localparam regIdxT flagRegIdx  = 6'd1; // r1 holds the compare flags

  // Flag word layout
  localparam int flagBitEq = 0;
  localparam int flagBitLt = 1;
  localparam int flagBitGt = 2;

  localparam wordT stackStep = 32'd4; // Push grows upward
  localparam wordT shortStep = 32'd4;
  localparam wordT longStep  = 32'd8; // Opcode word plus constant word

  typedef enum logic [7:0] {
    MovRC    = 8'h01, MovRR    = 8'h02, MovRdC   = 8'h03, MovRdR   = 8'h04,
    MovRdRo  = 8'h05, MovdCR   = 8'h06, MovdRoR  = 8'h07,
    AddRRR   = 8'h10, AddRRC   = 8'h11, SubRRR   = 8'h12, SubRRC   = 8'h13,
    IncR     = 8'h14, DecR     = 8'h15, ShlRRR   = 8'h16, ShrRRR   = 8'h17,
    NegRR    = 8'h18,
    CmpRR    = 8'h20, CmpRC    = 8'h21, CmpERRR  = 8'h22, CmpLtRRR = 8'h23,
    JmpC     = 8'h30, JeC      = 8'h31, JneC     = 8'h32, JzRC     = 8'h33,
    JnzRC    = 8'h34,
    PushR    = 8'h40, PopR     = 8'h41,
    Stall    = 8'h50
  } opcodeE;

  // Opcode in the low byte, register fields above it
  typedef struct packed {
    logic [7:0] regC;
    logic [7:0] regB;
    logic [7:0] regA;
    opcodeE     opcode;
  } instrWordT;

  // Opcodes followed by a 32-bit constant word
  function automatic logic isLongOp(opcodeE op);
    case (op)
      MovRC, MovRdC, MovRdRo, MovdCR, MovdRoR,
      AddRRC, SubRRC, CmpRC,
      JmpC, JeC, JneC, JzRC, JnzRC: return 1'b1;
      default:                      return 1'b0;
    endcase
  endfunction

endpackage

/* core/controlSequencer.sv */
`timescale 1ns/1ns

module controlSequencer #(
  parameter  int numRegs = 64,
  localparam int idxW = $clog2(numRegs)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  cpuIsaPkg::wordT       ramIn,
  output cpuCorePkg::busReqT    busReq,
  output cpuIsaPkg::opcodeE     opcode,
  input  cpuCorePkg::decodedOpT decoded,
  output logic [idxW-1:0]       regIdxA,
  output logic [idxW-1:0]       regIdxB,
  output logic [idxW-1:0]       regIdxC,
  input  cpuIsaPkg::wordT       rdDataA,
  input  cpuIsaPkg::wordT       rdDataB,
  input  cpuIsaPkg::wordT       rdDataC,
  input  cpuIsaPkg::wordT       memAddr,
  input  cpuIsaPkg::wordT       memData,
  output cpuIsaPkg::wordT       opA,
  output cpuIsaPkg::wordT       opB,
  output cpuIsaPkg::wordT       opC,
  output cpuIsaPkg::wordT       constWord,
  output cpuIsaPkg::wordT       loadValue,
  output cpuIsaPkg::wordT       curIp,
  input  cpuIsaPkg::wordT       nextIp,
  output logic                  writeBackEn
);

  import cpuIsaPkg::*;
  import cpuCorePkg::*;

  seqStateE  state;
  instrWordT instr;
  wordT      addrQ;
  wordT      wrDataQ;
  logic      readQ;
  logic      writeQ;

  assign busReq = '{addr: addrQ, wrData: wrDataQ, readReq: readQ, writeReq: writeQ};

  assign opcode = instr.opcode;
  assign regIdxA = instr.regA[idxW-1:0]; // Upper index bits ignored
  assign regIdxB = instr.regB[idxW-1:0];
  assign regIdxC = instr.regC[idxW-1:0];
  assign writeBackEn = (state == writeBack);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= fetchReq;
      readQ <= 1'b0;
      writeQ <= 1'b0;
      curIp <= '0;
    end else begin
      case (state)
        fetchReq: begin
          readQ <= 1'b1; // Instruction word read
          state <= fetchWait;
        end
        fetchWait: begin
          readQ <= 1'b0;
          state <= decode;
        end
        decode: state <= operandRead; // Word arrives on this edge
        operandRead: begin
          if (decoded.isLong) begin
            readQ <= 1'b1; // Constant word read
            state <= constWait;
          end else if (decoded.memKind != memNone) begin
            state <= memReq;
          end else begin
            state <= writeBack;
          end
        end
        constWait: begin
          readQ <= 1'b0;
          state <= constLatch;
        end
        constLatch: state <= (decoded.memKind != memNone) ? memReq : writeBack;
        memReq: begin
          readQ <= (decoded.memKind == memRead);
          writeQ <= (decoded.memKind == memWrite);
          state <= memWait;
        end
        memWait: begin
          // One-cycle strobes
          readQ <= 1'b0;
          writeQ <= 1'b0;
          state <= memLatch;
        end
        memLatch: state <= writeBack;
        writeBack: begin
          curIp <= nextIp;
          state <= fetchReq;
        end
        default: state <= fetchReq;
      endcase
    end
  end

  // Datapath latches
  always_ff @(posedge clk) begin
    case (state)
      fetchReq: addrQ <= curIp;
      decode:   instr <= ramIn;
      operandRead: begin
        opA <= rdDataA;
        opB <= rdDataB;
        opC <= rdDataC;
        addrQ <= curIp + shortStep; // Constant follows the opcode word
      end
      constLatch: constWord <= ramIn;
      memReq: begin
        addrQ <= memAddr;
        wrDataQ <= memData;
      end
      memLatch: loadValue <= ramIn; // Kept for loads and pops alike
      default: ;
    endcase
  end

endmodule

/* core/decodeUnit.sv */
`timescale 1ns/1ns

module decodeUnit (
  input  cpuIsaPkg::opcodeE     opcode,
  output cpuCorePkg::decodedOpT decoded
);

  import cpuIsaPkg::*;
  import cpuCorePkg::*;

  always_comb begin
    // Defaults give a short no-op
    decoded = '0;
    decoded.opcode = opcode;
    decoded.isLong = isLongOp(opcode);
    decoded.memKind = memNone;
    decoded.spDelta = spNone;

    case (opcode)
      // Register results straight from the ALU
      MovRC, MovRR, AddRRR, AddRRC, SubRRR, SubRRC, IncR, DecR,
      ShlRRR, ShrRRR, NegRR, CmpRR, CmpRC, CmpERRR, CmpLtRRR: begin
        decoded.writesDest = 1'b1;
      end

      MovRdC, MovRdR, MovRdRo: begin // Loads
        decoded.memKind = memRead;
        decoded.writesDest = 1'b1;
        decoded.destFromLoad = 1'b1;
      end

      MovdCR, MovdRoR: decoded.memKind = memWrite; // Stores

      PushR: begin
        decoded.memKind = memWrite;
        decoded.spDelta = spPlus;
      end

      PopR: begin
        decoded.memKind = memRead;
        decoded.writesDest = 1'b1;
        decoded.destFromLoad = 1'b1;
        decoded.spDelta = spMinus;
      end

      JmpC, JeC, JneC, JzRC, JnzRC: decoded.isJump = 1'b1;

      Stall: decoded.haltsIp = 1'b1; // Refetch itself forever

      default: ; // Unknown opcode only advances the pointer
    endcase
  end

endmodule

/* core/executeUnit.sv */
`timescale 1ns/1ns

module executeUnit (
  input  cpuCorePkg::decodedOpT decoded,
  input  cpuIsaPkg::wordT       opA,
  input  cpuIsaPkg::wordT       opB,
  input  cpuIsaPkg::wordT       opC,
  input  cpuIsaPkg::wordT       constWord,
  input  cpuIsaPkg::wordT       stackPtr,
  input  cpuIsaPkg::wordT       flags,
  output cpuIsaPkg::wordT       aluResult,
  output cpuIsaPkg::wordT       memAddr,
  output cpuIsaPkg::wordT       memData,
  output logic                  takeBranch
);

  import cpuIsaPkg::*;

  wordT cmpRhs;
  wordT flagWord;

  // Flag compare keeps the upper bits of r1
  always_comb begin
    cmpRhs = (decoded.opcode == CmpRC) ? constWord : opB;
    flagWord = flags;
    flagWord[flagBitEq] = (opA == cmpRhs);
    flagWord[flagBitLt] = (opA < cmpRhs); // Unsigned compare
    flagWord[flagBitGt] = (opA > cmpRhs);
  end

  always_comb begin
    case (decoded.opcode)
      MovRC:    aluResult = constWord;
      MovRR:    aluResult = opB;
      AddRRR:   aluResult = opB + opC;
      AddRRC:   aluResult = opB + constWord;
      SubRRR:   aluResult = opB - opC;
      SubRRC:   aluResult = opB - constWord;
      IncR:     aluResult = opA + 32'd1;
      DecR:     aluResult = opA - 32'd1;
      ShlRRR:   aluResult = opB << opC; // Zero for amounts of 32 and up
      ShrRRR:   aluResult = opB >> opC;
      NegRR:    aluResult = -opB;
      CmpRR,
      CmpRC:    aluResult = flagWord;
      CmpERRR:  aluResult = {31'd0, opB == opC};
      CmpLtRRR: aluResult = {31'd0, opB < opC};
      default:  aluResult = '0;
    endcase
  end

  // Data address generation
  always_comb begin
    case (decoded.opcode)
      MovRdC, MovdCR: memAddr = constWord;
      MovRdR:         memAddr = opB;
      MovRdRo:        memAddr = constWord + opB;
      MovdRoR:        memAddr = constWord + opA;
      PushR:          memAddr = stackPtr;
      PopR:           memAddr = stackPtr - stackStep; // Top of stack
      default:        memAddr = '0;
    endcase
  end

  assign memData = (decoded.opcode == PushR) ? opA : opB;

  always_comb begin
    case (decoded.opcode)
      JmpC:    takeBranch = 1'b1;
      JeC:     takeBranch = flags[flagBitEq];
      JneC:    takeBranch = !flags[flagBitEq];
      JzRC:    takeBranch = (opC == '0);
      JnzRC:   takeBranch = (opC != '0);
      default: takeBranch = 1'b0;
    endcase
  end

endmodule

/* core/registerFile.sv */
`timescale 1ns/1ns

module registerFile #(
  parameter  int numRegs = 64,
  localparam int idxW = $clog2(numRegs)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [idxW-1:0]      rdIdxA,
  input  logic [idxW-1:0]      rdIdxB,
  input  logic [idxW-1:0]      rdIdxC,
  output cpuIsaPkg::wordT      rdDataA,
  output cpuIsaPkg::wordT      rdDataB,
  output cpuIsaPkg::wordT      rdDataC,
  input  cpuCorePkg::regWriteT regWrite,
  input  logic                 spWrite,
  input  cpuIsaPkg::wordT      spData,
  output cpuIsaPkg::wordT      stackPtr,
  output cpuIsaPkg::wordT      flags
);

  import cpuIsaPkg::*;

  wordT regs [numRegs];

  // Asynchronous read ports
  assign rdDataA = regs[rdIdxA];
  assign rdDataB = regs[rdIdxB];
  assign rdDataC = regs[rdIdxC];
  assign stackPtr = regs[stackRegIdx];
  assign flags = regs[flagRegIdx]; // Seen by compares and branches

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++)
        regs[i] <= '0;
    end else begin
      if (spWrite)
        regs[stackRegIdx] <= spData;
      // Issued second so a PopR into r0 keeps the loaded word
      if (regWrite.en)
        regs[regWrite.idx] <= regWrite.data;
    end
  end

endmodule

/* core/resultUnit.sv */
`timescale 1ns/1ns

module resultUnit (
  input  cpuCorePkg::decodedOpT decoded,
  input  cpuIsaPkg::wordT       aluResult,
  input  cpuIsaPkg::wordT       loadValue,
  input  cpuIsaPkg::wordT       constWord,
  input  cpuIsaPkg::wordT       curIp,
  input  cpuIsaPkg::wordT       stackPtr,
  input  logic                  takeBranch,
  input  cpuIsaPkg::regIdxT     destIdx,
  output cpuCorePkg::regWriteT  regWrite,
  output logic                  spWrite,
  output cpuIsaPkg::wordT       spData,
  output cpuIsaPkg::wordT       nextIp
);

  import cpuIsaPkg::*;
  import cpuCorePkg::*;

  logic toFlags;

  assign toFlags = decoded.opcode inside {CmpRR, CmpRC}; // Flag compares land in r1

  always_comb begin
    regWrite.en = decoded.writesDest;
    regWrite.idx = toFlags ? flagRegIdx : destIdx;
    regWrite.data = decoded.destFromLoad ? loadValue : aluResult;
  end

  // Stack pointer update
  always_comb begin
    spWrite = (decoded.spDelta != spNone);
    case (decoded.spDelta)
      spPlus:  spData = stackPtr + stackStep;
      spMinus: spData = stackPtr - stackStep;
      default: spData = stackPtr;
    endcase
  end

  always_comb begin
    if (decoded.isJump && takeBranch)
      nextIp = constWord; // Absolute target
    else if (decoded.haltsIp)
      nextIp = curIp;
    else
      nextIp = curIp + (decoded.isLong ? longStep : shortStep);
  end

endmodule

/* rtl/cpuCore.sv */
`timescale 1ns/1ns

module cpuCore (
  input  logic            clk,
  input  logic            reset,
  input  cpuIsaPkg::wordT ramIn,
  output cpuIsaPkg::wordT ramAddress,
  output cpuIsaPkg::wordT ramOut,
  output logic            readReq,
  output logic            writeReq
);

  import cpuIsaPkg::*;
  import cpuCorePkg::*;

  localparam int numRegs = 64;
  localparam int idxW = $clog2(numRegs);

  busReqT          busReq;
  opcodeE          opcode;
  decodedOpT       decoded;
  logic [idxW-1:0] regIdxA, regIdxB, regIdxC;
  wordT            rdDataA, rdDataB, rdDataC;
  wordT            stackPtr, flags;
  wordT            opA, opB, opC;
  wordT            constWord, loadValue, curIp, nextIp;
  wordT            aluResult, memAddr, memData;
  logic            takeBranch;
  regWriteT        rfWrite, gatedWrite;
  logic            spWrite, gatedSpWrite, writeBackEn;
  wordT            spData;

  // Bus ports straight from the sequencer registers
  assign ramAddress = busReq.addr;
  assign ramOut = busReq.wrData;
  assign readReq = busReq.readReq;
  assign writeReq = busReq.writeReq;

  // Register writes only land in write-back
  assign gatedWrite = '{en: rfWrite.en & writeBackEn, idx: rfWrite.idx, data: rfWrite.data};
  assign gatedSpWrite = spWrite & writeBackEn;

  controlSequencer #(.numRegs(numRegs)) seq_i (
    .clk, .reset, .ramIn, .busReq, .opcode, .decoded,
    .regIdxA, .regIdxB, .regIdxC, .rdDataA, .rdDataB, .rdDataC,
    .memAddr, .memData, .opA, .opB, .opC, .constWord, .loadValue,
    .curIp, .nextIp, .writeBackEn
  );

  decodeUnit dec_i (.opcode, .decoded);

  registerFile #(.numRegs(numRegs)) regs_i (
    .clk, .reset,
    .rdIdxA(regIdxA), .rdIdxB(regIdxB), .rdIdxC(regIdxC),
    .rdDataA, .rdDataB, .rdDataC,
    .regWrite(gatedWrite), .spWrite(gatedSpWrite), .spData,
    .stackPtr, .flags
  );

  executeUnit exe_i (
    .decoded, .opA, .opB, .opC, .constWord, .stackPtr, .flags,
    .aluResult, .memAddr, .memData, .takeBranch
  );

  resultUnit res_i (
    .decoded, .aluResult, .loadValue, .constWord, .curIp, .stackPtr,
    .takeBranch, .destIdx(regIdxA), .regWrite(rfWrite), .spWrite, .spData, .nextIp
  );

endmodule

/* src.f */
common/cpuIsaPkg.sv
common/cpuCorePkg.sv
core/decodeUnit.sv
core/registerFile.sv
core/executeUnit.sv
core/resultUnit.sv
core/controlSequencer.sv
rtl/cpuCore.sv
testbench/cpuCoreTb.sv

/* testbench/cpuCoreTb.sv */
`timescale 1ns/1ns

module cpuCoreTb;

  import cpuIsaPkg::*;

  localparam int numInstr = 60;
  localparam int timeoutNs = (numInstr * 10 * 10 * 2) + 100; // Plus reset time
  localparam wordT dataBase = 32'h0000_0400;
  localparam wordT probeAddr = 32'h0000_0600; // Every written register lands here
  localparam wordT stackBase = 32'h0000_0800;

  // One expected bus access
  typedef struct packed {
    logic isWrite;
    logic isFetch;
    wordT addr;
    wordT data;
    wordT gap; // Cycles since the previous fetch or 0 when unchecked
  } busEventT;

  logic clk;
  logic reset;
  wordT ramIn = '0;
  wordT ramAddress;
  wordT ramOut;
  logic readReq;
  logic writeReq;

  wordT mem [1024];      // 4 KB bus memory
  wordT modelMem [1024];
  wordT modelRegs [64];
  busEventT expEvents [$];
  integer seed;
  wordT genIp = '0;
  int emitted = 0;
  wordT stallIp;
  int cycleCount = 0;
  int lastFetchCycle = 0;
  int stallRefetches = 0;

  cpuCore dut_i (.clk, .reset, .ramIn, .ramAddress, .ramOut, .readReq, .writeReq);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input wordT expected, input wordT actual);
    if (expected !== actual)
      abortRun($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
  endtask

  function automatic int urand(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic wordT randWord();
    wordT r;
    r = $random(seed);
    return r[5] ? (r & 32'h1f) : r; // Small values hit equal flags and shift amounts
  endfunction

  function automatic logic [7:0] randReg();
    return 8'(2 + urand(6)); // r2 to r7
  endfunction

  function automatic logic [7:0] randSrc();
    return 8'(urand(10)); // Includes sp, flags, data base and the zero in r9
  endfunction

  function automatic wordT dataOffset();
    return wordT'(4 * urand(32));
  endfunction

  // Opcodes that carry a constant word
  function automatic logic hasConstWord(input opcodeE op);
    case (op)
      MovRC, MovRdC, MovRdRo, MovdCR, MovdRoR, AddRRC, SubRRC, CmpRC,
      JmpC, JeC, JneC, JzRC, JnzRC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Unsigned compare into bit 0 equal, bit 1 less and bit 2 greater
  function automatic wordT compareFlags(input wordT old, input wordT x, input wordT y);
    wordT f;
    f = old;
    f[0] = (x == y);
    f[1] = (x < y);
    f[2] = (x > y);
    return f;
  endfunction

  task automatic emit(input opcodeE op, input logic [7:0] a, input logic [7:0] b,
                      input logic [7:0] c, input wordT k);
    wordT constAddr;
    constAddr = genIp + 4;
    mem[genIp[11:2]] = {c, b, a, op};
    if (hasConstWord(op)) begin
      mem[constAddr[11:2]] = k;
      genIp = genIp + 8;
    end else begin
      genIp = genIp + 4;
    end
    emitted++;
  endtask

  task automatic probe(input logic [7:0] r);
    emit(MovdCR, 0, r, 0, probeAddr);
  endtask

  // Jump over an IncR of dest followed by a probe of dest
  task automatic jumpOverInc(input opcodeE jop, input logic [7:0] c, input logic [7:0] dest);
    emit(jop, 0, 0, c, genIp + 12); // Target skips the IncR
    emit(IncR, dest, 0, 0, 0);
    probe(dest);
  endtask

  task automatic buildProgram();
    logic [7:0] d;
    logic [7:0] s;
    logic [7:0] pr;
    logic doProbe;
    opcodeE jop;
    int depth;
    depth = 0;
    emit(MovRC, 0, 0, 0, stackBase); // Stack pointer
    emit(MovRC, 8, 0, 0, dataBase);  // r8 stays the data base
    // Every conditional jump once taken and once not taken
    for (int pass = 0; pass < 2; pass++) begin
      if (pass == 0)
        emit(CmpRR, 8, 8, 0, 0); // Equal flag set
      else
        emit(CmpRC, 8, 0, 0, '0); // Equal flag clear
      probe(8'd1);
      jumpOverInc(JeC, 8'd9, 8'd2);
      jumpOverInc(JneC, 8'd9, 8'd2);
      jumpOverInc(JzRC, pass == 0 ? 8'd9 : 8'd8, 8'd2); // r9 zero, r8 nonzero
      jumpOverInc(JnzRC, pass == 0 ? 8'd9 : 8'd8, 8'd2);
    end
    while (emitted < numInstr - 5) begin
      d = randReg();
      s = randSrc();
      pr = d;
      doProbe = 1'b1;
      case (urand(11))
        0: emit(MovRC, d, 0, 0, randWord());
        1: emit(urand(2) != 0 ? MovRR : NegRR, d, s, 0, 0);
        2: emit(urand(2) != 0 ? AddRRR : SubRRR, d, s, randSrc(), 0);
        3: emit(urand(2) != 0 ? AddRRC : SubRRC, d, s, 0, randWord());
        4: emit(urand(2) != 0 ? ShlRRR : ShrRRR, d, s, randSrc(), 0);
        5: emit(urand(2) != 0 ? IncR : DecR, d, 0, 0, 0);
        6: begin
          case (urand(4))
            0: begin
              emit(CmpRR, s, urand(2) != 0 ? s : randSrc(), 0, 0); // Same reg sets eq
              pr = 8'd1;
            end
            1: begin
              emit(CmpRC, s, 0, 0, randWord());
              pr = 8'd1;
            end
            2: emit(CmpERRR, d, s, randSrc(), 0);
            default: emit(CmpLtRRR, d, s, randSrc(), 0);
          endcase
        end
        7: begin // Loads from the data region
          case (urand(3))
            0: emit(MovRdC, d, 0, 0, dataBase + dataOffset());
            1: emit(MovRdR, d, 8, 0, 0);
            default: emit(MovRdRo, d, 8, 0, dataOffset());
          endcase
        end
        8: begin
          doProbe = 1'b0;
          if (urand(2) != 0)
            emit(MovdCR, 0, s, 0, dataBase + dataOffset());
          else
            emit(MovdRoR, 8, s, 0, dataOffset());
        end
        9: begin
          if (depth > 0 && urand(2) != 0) begin
            emit(PopR, d, 0, 0, 0);
            probe(d);
            depth--;
          end else begin
            emit(PushR, s, 0, 0, 0);
            depth++;
          end
          pr = 8'd0; // Stack pointer afterwards
        end
        default: begin
          case (urand(5))
            0: jop = JmpC;
            1: jop = JeC;
            2: jop = JneC;
            3: jop = JzRC;
            default: jop = JnzRC;
          endcase
          doProbe = 1'b0;
          jumpOverInc(jop, urand(4) == 0 ? 8'd9 : randReg(), d); // r9 is always zero
        end
      endcase
      if (doProbe)
        probe(pr);
    end
    emit(Stall, 0, 0, 0, 0);
  endtask

  task automatic addExpected(input logic isWrite, input logic isFetch, input wordT addr,
                             input wordT data, input int gap);
    expEvents.push_back('{isWrite: isWrite, isFetch: isFetch, addr: addr, data: data,
                          gap: wordT'(gap)});
  endtask

  task automatic modelLoad(input logic [5:0] dest, input wordT addr);
    addExpected(1'b0, 1'b0, addr, '0, 0);
    modelRegs[dest] = modelMem[addr[11:2]];
  endtask

  task automatic modelStore(input wordT addr, input wordT data);
    addExpected(1'b1, 1'b0, addr, data, 0);
    modelMem[addr[11:2]] = data;
  endtask

  // Instruction set model stepping one instruction per loop pass
  task automatic runModel();
    wordT w;
    opcodeE op;
    logic [5:0] a;
    logic [5:0] b;
    logic [5:0] c;
    wordT ip, k, opA, opB, opC, sp, nextIp, constAddr;
    logic isLong;
    logic done;
    int cycles;
    int prevCycles;
    int steps;
    ip = '0;
    done = 1'b0;
    prevCycles = 0;
    steps = 0;
    for (int i = 0; i < 64; i++)
      modelRegs[i] = '0;
    while (!done && steps < 1000) begin
      w = modelMem[ip[11:2]];
      op = opcodeE'(w[7:0]);
      a = w[13:8];
      b = w[21:16];
      c = w[29:24];
      opA = modelRegs[a];
      opB = modelRegs[b];
      opC = modelRegs[c];
      sp = modelRegs[0];
      isLong = hasConstWord(op);
      constAddr = ip + 4;
      k = modelMem[constAddr[11:2]];
      addExpected(1'b0, 1'b1, ip, '0, prevCycles);
      if (isLong)
        addExpected(1'b0, 1'b0, constAddr, '0, 0);
      cycles = isLong ? 7 : 5;
      nextIp = ip + (isLong ? 32'd8 : 32'd4);
      case (op)
        MovRC:    modelRegs[a] = k;
        MovRR:    modelRegs[a] = opB;
        AddRRR:   modelRegs[a] = opB + opC;
        AddRRC:   modelRegs[a] = opB + k;
        SubRRR:   modelRegs[a] = opB - opC;
        SubRRC:   modelRegs[a] = opB - k;
        IncR:     modelRegs[a] = opA + 1;
        DecR:     modelRegs[a] = opA - 1;
        ShlRRR:   modelRegs[a] = opB << opC;
        ShrRRR:   modelRegs[a] = opB >> opC;
        NegRR:    modelRegs[a] = -opB;
        CmpRR:    modelRegs[1] = compareFlags(modelRegs[1], opA, opB);
        CmpRC:    modelRegs[1] = compareFlags(modelRegs[1], opA, k);
        CmpERRR:  modelRegs[a] = {31'd0, opB == opC};
        CmpLtRRR: modelRegs[a] = {31'd0, opB < opC};
        MovRdC:   modelLoad(a, k);
        MovRdR:   modelLoad(a, opB);
        MovRdRo:  modelLoad(a, k + opB);
        MovdCR:   modelStore(k, opB);
        MovdRoR:  modelStore(k + opA, opB);
        PushR: begin
          modelStore(sp, opA);
          modelRegs[0] = sp + 4;
        end
        PopR: begin
          modelRegs[0] = sp - 4;
          modelLoad(a, sp - 4); // Loaded word wins for r0
        end
        JmpC:  nextIp = k;
        JeC:   nextIp = modelRegs[1][0] ? k : nextIp;
        JneC:  nextIp = modelRegs[1][0] ? nextIp : k;
        JzRC:  nextIp = (opC == 0) ? k : nextIp;
        JnzRC: nextIp = (opC != 0) ? k : nextIp;
        Stall: begin
          done = 1'b1;
          stallIp = ip;
          nextIp = ip;
        end
        default: ; // Never generated
      endcase
      if (op inside {MovRdC, MovRdR, MovRdRo, MovdCR, MovdRoR, PushR, PopR})
        cycles += 3; // Data access phases
      prevCycles = cycles;
      ip = nextIp;
      steps++;
    end
    if (!done)
      abortRun("Reference model ran past its step limit without reaching Stall");
  endtask

  // Compare one observed access with the next expected one
  task automatic busAccess(input logic isWrite, input wordT addr, input wordT data);
    busEventT ev;
    if (expEvents.size() == 0) begin
      if (isWrite || addr != stallIp) begin
        abortRun("Bus access after the final Stall is not a refetch of the Stall address");
      end else begin
        check("stall refetch interval", 32'd5, 32'(cycleCount - lastFetchCycle));
        lastFetchCycle = cycleCount;
        stallRefetches++;
      end
    end else begin
      ev = expEvents.pop_front();
      check("access kind", 32'(ev.isWrite), 32'(isWrite));
      check(ev.isFetch ? "fetch address" : "data address", ev.addr, addr);
      if (isWrite)
        check("write data", ev.data, data);
      if (ev.isFetch) begin
        if (ev.gap != 0)
          check("fetch interval", ev.gap, 32'(cycleCount - lastFetchCycle));
        lastFetchCycle = cycleCount;
      end
    end
  endtask

  // Bus memory sampling the strobes mid-cycle
  always @(negedge clk) begin
    if (readReq && writeReq)
      abortRun("Read and write strobes were high in the same cycle");
    if (readReq) begin
      ramIn <= mem[ramAddress[11:2]];
      busAccess(1'b0, ramAddress, '0);
    end
    if (writeReq) begin
      mem[ramAddress[11:2]] = ramOut;
      busAccess(1'b1, ramAddress, ramOut);
    end
  end

  initial begin
    #(timeoutNs);
    abortRun("Watchdog expired before the core settled in its Stall loop");
  end

  initial begin
    seed = 17;
    reset = 1'b1;
    for (int i = 0; i < 1024; i++)
      mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'hC0DE_0000; // Fill spreads every address bit
    buildProgram();
    for (int i = 0; i < 1024; i++)
      modelMem[i] = mem[i];
    runModel();
    repeat (4) @(posedge clk);
    check("reset readReq", 32'd0, 32'(readReq));
    check("reset writeReq", 32'd0, 32'(writeReq));
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check("first fetch strobe", 32'd1, 32'(readReq)); // Issued on the first edge
    check("first fetch address", 32'd0, ramAddress);
    wait (stallRefetches >= 3);
    for (int i = 0; i < 1024; i++)
      check($sformatf("final memory word %0d", i), modelMem[i], mem[i]);
    $display("Test completed successfully");
    $finish;
  end

endmodule
